// ==== common/id_pkg.sv ====
`default_nettype none

package id_pkg;

    ////////////////////////////////////////
    // widths and base types
    ////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // destination used by a NOP
    localparam reg_addr_t NOP_REG = '0;

    // instruction field positions
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int SA_MSB    = 10;
    localparam int SA_LSB    = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;
    localparam int IMM_LSB   = 0;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } op_e;

    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'b000000,
        FUNCT_SRL  = 6'b000010,
        FUNCT_SRA  = 6'b000011,
        FUNCT_SLLV = 6'b000100,
        FUNCT_SRLV = 6'b000110,
        FUNCT_SRAV = 6'b000111,
        FUNCT_ADD  = 6'b100000,
        FUNCT_ADDU = 6'b100001,
        FUNCT_SUB  = 6'b100010,
        FUNCT_SUBU = 6'b100011,
        FUNCT_AND  = 6'b100100,
        FUNCT_OR   = 6'b100101,
        FUNCT_XOR  = 6'b100110,
        FUNCT_NOR  = 6'b100111,
        FUNCT_SLT  = 6'b101010,
        FUNCT_SLTU = 6'b101011
    } funct_e;

    // opcode handed to execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b00000000,
        ALU_SRL   = 8'b00000010,
        ALU_SRA   = 8'b00000011,
        ALU_ADD   = 8'b00100000,
        ALU_ADDU  = 8'b00100001,
        ALU_SUB   = 8'b00100010,
        ALU_SUBU  = 8'b00100011,
        ALU_AND   = 8'b00100100,
        ALU_OR    = 8'b00100101,
        ALU_XOR   = 8'b00100110,
        ALU_NOR   = 8'b00100111,
        ALU_SLT   = 8'b00101010,
        ALU_SLTU  = 8'b00101011,
        ALU_ADDI  = 8'b01010101,
        ALU_ADDIU = 8'b01010110,
        ALU_SLL   = 8'b01111100
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_e;

endpackage

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`default_nettype none

module instr_decoder #(
    parameter int NUM_READ_PORTS = 2
) (
    input  id_pkg::inst_t             inst_i,
    output id_pkg::alu_op_e           alu_op_o,
    output id_pkg::alu_sel_e          alu_sel_o,
    output logic                      wreg_o,
    output id_pkg::reg_addr_t         wd_o,
    output logic [NUM_READ_PORTS-1:0] rd_en_o,
    output id_pkg::reg_addr_t         rd_addr_o [NUM_READ_PORTS],
    output id_pkg::data_t             imm_o
);
    import id_pkg::*;

    op_e                    op;
    funct_e                 funct;
    reg_addr_t              rs;
    reg_addr_t              rt;
    reg_addr_t              rd;
    logic [SA_MSB-SA_LSB:0] sa;
    logic [IMM_W-1:0]       imm16;
    logic                   upper_zero;

    assign op    = op_e'(inst_i[OP_MSB:OP_LSB]);
    assign funct = funct_e'(inst_i[FUNCT_MSB:FUNCT_LSB]);
    assign rs    = inst_i[RS_MSB:RS_LSB];
    assign rt    = inst_i[RT_MSB:RT_LSB];
    assign rd    = inst_i[RD_MSB:RD_LSB];
    assign sa    = inst_i[SA_MSB:SA_LSB];
    assign imm16 = inst_i[IMM_MSB:IMM_LSB];

    // immediate shifts carry zero in op and rs
    assign upper_zero = (inst_i[OP_MSB:RS_LSB] == '0);

    always_comb begin
        alu_op_o     = ALU_NOP;
        alu_sel_o    = SEL_NOP;
        wreg_o       = 1'b0;
        wd_o         = NOP_REG;
        rd_en_o      = '0;
        imm_o        = '0;
        rd_addr_o[0] = rs;
        rd_addr_o[1] = rt;
        // extra ports beyond rs/rt are never read
        for (int p = 2; p < NUM_READ_PORTS; p++) begin
            rd_addr_o[p] = NOP_REG;
        end

        case (op)
            OP_SPECIAL: begin
                if (upper_zero &&
                    (funct == FUNCT_SLL || funct == FUNCT_SRL || funct == FUNCT_SRA)) begin
                    // shift amount travels as the immediate on port 0
                    alu_sel_o  = SEL_SHIFT;
                    wreg_o     = 1'b1;
                    wd_o       = rd;
                    rd_en_o[1] = 1'b1;
                    imm_o      = DATA_W'(sa);
                    case (funct)
                        FUNCT_SRL: alu_op_o = ALU_SRL;
                        FUNCT_SRA: alu_op_o = ALU_SRA;
                        default:   alu_op_o = ALU_SLL;
                    endcase
                end else if (sa == '0) begin
                    case (funct)
                        FUNCT_OR:   alu_op_o = ALU_OR;
                        FUNCT_AND:  alu_op_o = ALU_AND;
                        FUNCT_XOR:  alu_op_o = ALU_XOR;
                        FUNCT_NOR:  alu_op_o = ALU_NOR;
                        FUNCT_SLLV: alu_op_o = ALU_SLL;
                        FUNCT_SRLV: alu_op_o = ALU_SRL;
                        FUNCT_SRAV: alu_op_o = ALU_SRA;
                        FUNCT_SLT:  alu_op_o = ALU_SLT;
                        FUNCT_SLTU: alu_op_o = ALU_SLTU;
                        FUNCT_ADD:  alu_op_o = ALU_ADD;
                        FUNCT_ADDU: alu_op_o = ALU_ADDU;
                        FUNCT_SUB:  alu_op_o = ALU_SUB;
                        FUNCT_SUBU: alu_op_o = ALU_SUBU;
                        default:    alu_op_o = ALU_NOP;
                    endcase
                    case (funct)
                        FUNCT_OR, FUNCT_AND, FUNCT_XOR, FUNCT_NOR: alu_sel_o = SEL_LOGIC;
                        FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV:       alu_sel_o = SEL_SHIFT;
                        FUNCT_SLT, FUNCT_SLTU, FUNCT_ADD, FUNCT_ADDU,
                        FUNCT_SUB, FUNCT_SUBU:                     alu_sel_o = SEL_ARITH;
                        default:                                   alu_sel_o = SEL_NOP;
                    endcase
                    // any recognised funct reads rs and rt and writes rd
                    if (alu_op_o != ALU_NOP) begin
                        wreg_o       = 1'b1;
                        wd_o         = rd;
                        rd_en_o[1:0] = 2'b11;
                    end
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
                alu_sel_o  = SEL_LOGIC;
                wreg_o     = 1'b1;
                wd_o       = rt;
                rd_en_o[0] = 1'b1;
                imm_o      = {{(DATA_W-IMM_W){1'b0}}, imm16};
                case (op)
                    OP_ANDI: alu_op_o = ALU_AND;
                    OP_XORI: alu_op_o = ALU_XOR;
                    default: alu_op_o = ALU_OR;
                endcase
                // lui is an or of zero with the shifted field
                if (op == OP_LUI) begin
                    imm_o = {imm16, {(DATA_W-IMM_W){1'b0}}};
                end
            end
            OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
                alu_sel_o  = SEL_ARITH;
                wreg_o     = 1'b1;
                wd_o       = rt;
                rd_en_o[0] = 1'b1;
                imm_o      = {{(DATA_W-IMM_W){imm16[IMM_W-1]}}, imm16};
                case (op)
                    OP_SLTI:  alu_op_o = ALU_SLT;
                    OP_SLTIU: alu_op_o = ALU_SLTU;
                    OP_ADDI:  alu_op_o = ALU_ADDI;
                    default:  alu_op_o = ALU_ADDIU;
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/operand_select.sv ====
`default_nettype none

module operand_select #(
    parameter int NUM_FWD = 2
) (
    input  logic               rd_en_i,
    input  id_pkg::reg_addr_t  rd_addr_i,
    input  id_pkg::data_t      reg_data_i,
    input  id_pkg::data_t      imm_i,
    input  logic [NUM_FWD-1:0] fwd_we_i,
    input  id_pkg::reg_addr_t  fwd_wd_i [NUM_FWD],
    input  id_pkg::data_t      fwd_data_i [NUM_FWD],
    output id_pkg::data_t      operand_o
);
    import id_pkg::*;

    logic  fwd_hit;
    data_t fwd_value;

    // walk from the far end so the lowest index wins
    always_comb begin
        fwd_hit   = 1'b0;
        fwd_value = '0;
        for (int i = NUM_FWD - 1; i >= 0; i--) begin
            if (fwd_we_i[i] && (fwd_wd_i[i] == rd_addr_i)) begin
                fwd_hit   = 1'b1;
                fwd_value = fwd_data_i[i];
            end
        end
    end

    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (fwd_hit) begin
            operand_o = fwd_value;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_ex_register.sv ====
`default_nettype none

module id_ex_register #(
    parameter int NUM_READ_PORTS = 2
) (
    input  logic              clk,
    input  logic              rst_i,
    input  id_pkg::data_t     pc_i,
    input  id_pkg::alu_op_e   alu_op_i,
    input  id_pkg::alu_sel_e  alu_sel_i,
    input  logic              wreg_i,
    input  id_pkg::reg_addr_t wd_i,
    input  id_pkg::data_t     operand_i [NUM_READ_PORTS],
    output id_pkg::data_t     pc_o,
    output id_pkg::alu_op_e   alu_op_o,
    output id_pkg::alu_sel_e  alu_sel_o,
    output logic              wreg_o,
    output id_pkg::reg_addr_t wd_o,
    output id_pkg::data_t     operand_o [NUM_READ_PORTS]
);
    import id_pkg::*;

    // reset loads a nop into execute
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o      <= '0;
            alu_op_o  <= ALU_NOP;
            alu_sel_o <= SEL_NOP;
            wreg_o    <= 1'b0;
            wd_o      <= NOP_REG;
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                operand_o[p] <= '0;
            end
        end else begin
            pc_o      <= pc_i;
            alu_op_o  <= alu_op_i;
            alu_sel_o <= alu_sel_i;
            wreg_o    <= wreg_i;
            wd_o      <= wd_i;
            for (int p = 0; p < NUM_READ_PORTS; p++) begin
                operand_o[p] <= operand_i[p];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
`default_nettype none

module id_stage #(
    parameter int NUM_READ_PORTS = 2,
    parameter int NUM_FWD        = 2
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  id_pkg::data_t             pc_i,
    input  id_pkg::inst_t             inst_i,
    output logic [NUM_READ_PORTS-1:0] rd_en_o,
    output id_pkg::reg_addr_t         rd_addr_o [NUM_READ_PORTS],
    input  id_pkg::data_t             reg_data_i [NUM_READ_PORTS],
    input  logic [NUM_FWD-1:0]        fwd_we_i,
    input  id_pkg::reg_addr_t         fwd_wd_i [NUM_FWD],
    input  id_pkg::data_t             fwd_data_i [NUM_FWD],
    output id_pkg::data_t             pc_o,
    output id_pkg::alu_op_e           alu_op_o,
    output id_pkg::alu_sel_e          alu_sel_o,
    output logic                      wreg_o,
    output id_pkg::reg_addr_t         wd_o,
    output id_pkg::data_t             operand_o [NUM_READ_PORTS]
);
    import id_pkg::*;

    alu_op_e   dec_alu_op;
    alu_sel_e  dec_alu_sel;
    logic      dec_wreg;
    reg_addr_t dec_wd;
    data_t     dec_imm;
    data_t     sel_operand [NUM_READ_PORTS];

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    instr_decoder #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) u_instr_decoder (
        .inst_i    (inst_i),
        .alu_op_o  (dec_alu_op),
        .alu_sel_o (dec_alu_sel),
        .wreg_o    (dec_wreg),
        .wd_o      (dec_wd),
        .rd_en_o   (rd_en_o),
        .rd_addr_o (rd_addr_o),
        .imm_o     (dec_imm)
    );

    // one operand mux per read port, execute forward first
    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_operand
        operand_select #(
            .NUM_FWD (NUM_FWD)
        ) u_operand_select (
            .rd_en_i    (rd_en_o[p]),
            .rd_addr_i  (rd_addr_o[p]),
            .reg_data_i (reg_data_i[p]),
            .imm_i      (dec_imm),
            .fwd_we_i   (fwd_we_i),
            .fwd_wd_i   (fwd_wd_i),
            .fwd_data_i (fwd_data_i),
            .operand_o  (sel_operand[p])
        );
    end

    ////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////

    id_ex_register #(
        .NUM_READ_PORTS (NUM_READ_PORTS)
    ) u_id_ex_register (
        .clk       (clk),
        .rst_i     (rst_i),
        .pc_i      (pc_i),
        .alu_op_i  (dec_alu_op),
        .alu_sel_i (dec_alu_sel),
        .wreg_i    (dec_wreg),
        .wd_i      (dec_wd),
        .operand_i (sel_operand),
        .pc_o      (pc_o),
        .alu_op_o  (alu_op_o),
        .alu_sel_o (alu_sel_o),
        .wreg_o    (wreg_o),
        .wd_o      (wd_o),
        .operand_o (operand_o)
    );

endmodule

`default_nettype wire

// ==== bench/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// operand by forwarding priority, immediate when the port is idle
function automatic id_pkg::data_t pick_operand(
    input logic              en,
    input id_pkg::reg_addr_t addr,
    input id_pkg::data_t     reg_val,
    input id_pkg::data_t     imm,
    input logic [1:0]        fwd_we,
    input id_pkg::reg_addr_t fwd_wd [2],
    input id_pkg::data_t     fwd_data [2]
);
    id_pkg::data_t result;
    logic          found;
    result = reg_val;
    found  = 1'b0;
    if (!en) begin
        return imm;
    end
    for (int i = 0; i < 2; i++) begin
        if (!found && fwd_we[i] && (fwd_wd[i] == addr)) begin
            result = fwd_data[i];
            found  = 1'b1;
        end
    end
    return result;
endfunction

function automatic void ref_decode(
    input  id_pkg::inst_t     inst,
    input  id_pkg::data_t     rs_val,
    input  id_pkg::data_t     rt_val,
    input  logic [1:0]        fwd_we,
    input  id_pkg::reg_addr_t fwd_wd [2],
    input  id_pkg::data_t     fwd_data [2],
    output id_pkg::alu_op_e   alu_op,
    output id_pkg::alu_sel_e  alu_sel,
    output logic              wreg,
    output id_pkg::reg_addr_t wd,
    output logic [1:0]        rd_en,
    output id_pkg::data_t     opnd0,
    output id_pkg::data_t     opnd1
);
    logic [5:0]    op;
    logic [5:0]    funct;
    logic [15:0]   imm16;
    logic          en0;
    logic          en1;
    id_pkg::data_t imm;
    op      = inst[31:26];
    funct   = inst[5:0];
    imm16   = inst[15:0];
    alu_op  = id_pkg::ALU_NOP;
    alu_sel = id_pkg::SEL_NOP;
    en0     = 1'b0;
    en1     = 1'b0;
    imm     = '0;
    if (op == id_pkg::OP_SPECIAL && (funct == id_pkg::FUNCT_SLL ||
        funct == id_pkg::FUNCT_SRL || funct == id_pkg::FUNCT_SRA)) begin
        // shift by sa needs op and rs all zero
        if (inst[31:21] == 11'd0) begin
            alu_sel = id_pkg::SEL_SHIFT;
            en1     = 1'b1;
            imm     = {27'd0, inst[10:6]};
            case (funct)
                id_pkg::FUNCT_SLL: alu_op = id_pkg::ALU_SLL;
                id_pkg::FUNCT_SRL: alu_op = id_pkg::ALU_SRL;
                default:           alu_op = id_pkg::ALU_SRA;
            endcase
        end
    end else if (op == id_pkg::OP_SPECIAL && inst[10:6] == 5'd0) begin
        case (funct)
            id_pkg::FUNCT_OR:   alu_op = id_pkg::ALU_OR;
            id_pkg::FUNCT_AND:  alu_op = id_pkg::ALU_AND;
            id_pkg::FUNCT_XOR:  alu_op = id_pkg::ALU_XOR;
            id_pkg::FUNCT_NOR:  alu_op = id_pkg::ALU_NOR;
            id_pkg::FUNCT_SLLV: alu_op = id_pkg::ALU_SLL;
            id_pkg::FUNCT_SRLV: alu_op = id_pkg::ALU_SRL;
            id_pkg::FUNCT_SRAV: alu_op = id_pkg::ALU_SRA;
            id_pkg::FUNCT_SLT:  alu_op = id_pkg::ALU_SLT;
            id_pkg::FUNCT_SLTU: alu_op = id_pkg::ALU_SLTU;
            id_pkg::FUNCT_ADD:  alu_op = id_pkg::ALU_ADD;
            id_pkg::FUNCT_ADDU: alu_op = id_pkg::ALU_ADDU;
            id_pkg::FUNCT_SUB:  alu_op = id_pkg::ALU_SUB;
            id_pkg::FUNCT_SUBU: alu_op = id_pkg::ALU_SUBU;
            default:            alu_op = id_pkg::ALU_NOP;
        endcase
        case (alu_op)
            id_pkg::ALU_NOP:                                   alu_sel = id_pkg::SEL_NOP;
            id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR,
            id_pkg::ALU_NOR:                                   alu_sel = id_pkg::SEL_LOGIC;
            id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA: alu_sel = id_pkg::SEL_SHIFT;
            default:                                           alu_sel = id_pkg::SEL_ARITH;
        endcase
        en0 = (alu_op != id_pkg::ALU_NOP);
        en1 = en0;
    end else if (op != id_pkg::OP_SPECIAL) begin
        case (op)
            id_pkg::OP_ORI, id_pkg::OP_LUI: alu_op = id_pkg::ALU_OR;
            id_pkg::OP_ANDI:                alu_op = id_pkg::ALU_AND;
            id_pkg::OP_XORI:                alu_op = id_pkg::ALU_XOR;
            id_pkg::OP_SLTI:                alu_op = id_pkg::ALU_SLT;
            id_pkg::OP_SLTIU:               alu_op = id_pkg::ALU_SLTU;
            id_pkg::OP_ADDI:                alu_op = id_pkg::ALU_ADDI;
            id_pkg::OP_ADDIU:               alu_op = id_pkg::ALU_ADDIU;
            default:                        alu_op = id_pkg::ALU_NOP;
        endcase
        case (op)
            id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI: begin
                alu_sel = id_pkg::SEL_LOGIC;
                imm     = {16'd0, imm16};
            end
            id_pkg::OP_LUI: begin
                alu_sel = id_pkg::SEL_LOGIC;
                imm     = {imm16, 16'd0};
            end
            id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_ADDI, id_pkg::OP_ADDIU: begin
                alu_sel = id_pkg::SEL_ARITH;
                imm     = {{16{imm16[15]}}, imm16};
            end
            default: begin
            end
        endcase
        en0 = (alu_op != id_pkg::ALU_NOP);
    end
    wreg = (alu_op != id_pkg::ALU_NOP);
    wd   = id_pkg::NOP_REG;
    if (wreg) begin
        wd = (op == id_pkg::OP_SPECIAL) ? inst[15:11] : inst[20:16];
    end
    rd_en = {en1, en0};
    opnd0 = pick_operand(en0, inst[25:21], rs_val, imm, fwd_we, fwd_wd, fwd_data);
    opnd1 = pick_operand(en1, inst[20:16], rt_val, imm, fwd_we, fwd_wd, fwd_data);
endfunction

`endif

// ==== bench/id_stage_tb.sv ====
`default_nettype none

module id_stage_tb;
    import id_pkg::*;

    `include "id_ref_model.svh"

    localparam int NUM_READ_PORTS = 2;
    localparam int NUM_FWD        = 2;
    localparam int NUM_INST       = 3000;

    localparam logic [5:0] RTYPE_FUNCT [13] = '{
        FUNCT_OR, FUNCT_AND, FUNCT_XOR, FUNCT_NOR, FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV,
        FUNCT_SLT, FUNCT_SLTU, FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB, FUNCT_SUBU
    };
    localparam logic [5:0] SHIFT_FUNCT [3] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
    localparam logic [5:0] IMM_OP [8] = '{
        OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU
    };
    // mult, hi/lo moves, conditional moves, sync
    localparam logic [5:0] DROP_FUNCT [9] = '{
        6'b011000, 6'b011001, 6'b010000, 6'b010001, 6'b010010,
        6'b010011, 6'b001011, 6'b001010, 6'b001111
    };

    logic                      clk;
    logic                      rst_i;
    data_t                     pc_i;
    inst_t                     inst_i;
    logic [NUM_READ_PORTS-1:0] rd_en_o;
    reg_addr_t                 rd_addr_o [NUM_READ_PORTS];
    data_t                     reg_data_i [NUM_READ_PORTS];
    logic [NUM_FWD-1:0]        fwd_we_i;
    reg_addr_t                 fwd_wd_i [NUM_FWD];
    data_t                     fwd_data_i [NUM_FWD];
    data_t                     pc_o;
    alu_op_e                   alu_op_o;
    alu_sel_e                  alu_sel_o;
    logic                      wreg_o;
    reg_addr_t                 wd_o;
    data_t                     operand_o [NUM_READ_PORTS];

    data_t regs [32];
    logic  stim_valid;
    int    checked;

    id_stage #(
        .NUM_READ_PORTS (NUM_READ_PORTS),
        .NUM_FWD        (NUM_FWD)
    ) u_id_stage (
        .clk        (clk),
        .rst_i      (rst_i),
        .pc_i       (pc_i),
        .inst_i     (inst_i),
        .rd_en_o    (rd_en_o),
        .rd_addr_o  (rd_addr_o),
        .reg_data_i (reg_data_i),
        .fwd_we_i   (fwd_we_i),
        .fwd_wd_i   (fwd_wd_i),
        .fwd_data_i (fwd_data_i),
        .pc_o       (pc_o),
        .alu_op_o   (alu_op_o),
        .alu_sel_o  (alu_sel_o),
        .wreg_o     (wreg_o),
        .wd_o       (wd_o),
        .operand_o  (operand_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // register file answers in the same cycle
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            reg_data_i[p] = regs[rd_addr_o[p]];
        end
    end

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic inst_t rand_inst();
        inst_t w;
        int    kind;
        w    = $urandom;
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1, 2: begin
                w[31:26] = OP_SPECIAL;
                w[10:6]  = 5'd0;
                w[5:0]   = RTYPE_FUNCT[$urandom_range(0, 12)];
            end
            3: begin
                w[31:21] = 11'd0;
                w[5:0]   = SHIFT_FUNCT[$urandom_range(0, 2)];
            end
            4, 5, 6: begin
                w[31:26] = IMM_OP[$urandom_range(0, 7)];
            end
            7: begin
                w[31:26] = OP_SPECIAL;
                w[5:0]   = DROP_FUNCT[$urandom_range(0, 8)];
            end
            8: begin
                // special2 (mul, clz, clo) or pref
                w[31:26] = ($urandom_range(0, 1) == 0) ? 6'b011100 : 6'b110011;
            end
            default: begin
            end
        endcase
        return w;
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        inst_t w;
        int    wait_cycles;
        void'($urandom(32'ha550ff93));
        rst_i      = 1'b1;
        // a live addu and pc that reset has to mask
        pc_i       = 32'h0040_0000;
        inst_i     = {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU};
        fwd_we_i   = '0;
        stim_valid = 1'b0;
        for (int i = 0; i < NUM_FWD; i++) begin
            fwd_wd_i[i]   = '0;
            fwd_data_i[i] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            regs[r] = $urandom;
        end
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        wait_cycles = 0;
        while (rst_i !== 1'b0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_i !== 1'b0) begin
            $display("reset never released");
            $display("tests failed");
            $fatal(1);
        end
        for (int n = 0; n < NUM_INST; n++) begin
            @(posedge clk);
            w = rand_inst();
            inst_i     <= w;
            pc_i       <= pc_i + 32'd4;
            stim_valid <= 1'b1;
            fwd_we_i   <= 2'($urandom);
            // forwards mostly aim at rs or rt
            for (int i = 0; i < NUM_FWD; i++) begin
                case ($urandom_range(0, 3))
                    0:       fwd_wd_i[i] <= w[25:21];
                    1:       fwd_wd_i[i] <= w[20:16];
                    default: fwd_wd_i[i] <= 5'($urandom);
                endcase
                fwd_data_i[i] <= $urandom;
            end
        end
        @(posedge clk);
        stim_valid <= 1'b0;
        wait_cycles = 0;
        while (checked < NUM_INST && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (checked == NUM_INST) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("timeout waiting for the last checks");
            $display("tests failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // compare
    ////////////////////////////////////////

    initial begin
        logic       s_rst;
        logic       s_valid;
        inst_t      s_inst;
        data_t      s_pc;
        logic [1:0] s_we;
        reg_addr_t  s_wd [2];
        data_t      s_data [2];
        logic [1:0] s_rd_en;
        reg_addr_t  s_rd_addr [2];
        alu_op_e    e_op;
        alu_sel_e   e_sel;
        logic       e_wreg;
        reg_addr_t  e_wd;
        logic [1:0] e_rd_en;
        data_t      e_opnd0;
        data_t      e_opnd1;
        checked = 0;
        forever begin
            @(posedge clk);
            s_rst     = rst_i;
            s_valid   = stim_valid;
            s_inst    = inst_i;
            s_pc      = pc_i;
            s_we      = fwd_we_i;
            s_wd      = fwd_wd_i;
            s_data    = fwd_data_i;
            // read ports still show the instruction being captured
            s_rd_en   = rd_en_o;
            s_rd_addr = rd_addr_o;
            @(negedge clk);
            ref_decode(s_inst, regs[s_inst[25:21]], regs[s_inst[20:16]], s_we, s_wd,
                       s_data, e_op, e_sel, e_wreg, e_wd, e_rd_en, e_opnd0, e_opnd1);
            if (s_rst) begin
                e_op    = ALU_NOP;
                e_sel   = SEL_NOP;
                e_wreg  = 1'b0;
                e_wd    = NOP_REG;
                e_opnd0 = '0;
                e_opnd1 = '0;
                s_pc    = '0;
            end
            check_field("rd_en_o", 32'(e_rd_en), 32'(s_rd_en));
            check_field("rd_addr_o[0]", 32'(s_inst[25:21]), 32'(s_rd_addr[0]));
            check_field("rd_addr_o[1]", 32'(s_inst[20:16]), 32'(s_rd_addr[1]));
            check_field("pc_o", s_pc, pc_o);
            check_field("alu_op_o", 32'(e_op), 32'(alu_op_o));
            check_field("alu_sel_o", 32'(e_sel), 32'(alu_sel_o));
            check_field("wreg_o", 32'(e_wreg), 32'(wreg_o));
            check_field("wd_o", 32'(e_wd), 32'(wd_o));
            check_field("operand_o[0]", e_opnd0, operand_o[0]);
            check_field("operand_o[1]", e_opnd1, operand_o[1]);
            if (s_valid && !s_rst) begin
                checked++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+bench
common/id_pkg.sv
decode/instr_decoder.sv
verilog/operand_select.sv
verilog/id_ex_register.sv
verilog/id_stage.sv
bench/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module id_stage_tb -f vlog.f

# a failing run exits nonzero, so keep going to print its output
out=$(./obj_dir/Vid_stage_tb 2>&1) || true
echo "$out"

echo "$out" | grep -q "all tests passed"
echo "simulation passed"
